// ==== verilog.f ====
verilog/nq_fmt_pkg.sv
verilog/scaler_io_pkg.sv
verilog/scaler_ingress.sv
verilog/nq_multiplier.sv
verilog/scaler_egress.sv
verilog/nq_scaler_top.sv
tb/nq_scaler_props.sv
tb/tb_nq_scaler.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the gain stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_nq_scaler \
  -f verilog.f \
  -o sim_tb_nq_scaler

./obj_dir/sim_tb_nq_scaler | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi
echo "Simulation passed"

// ==== tb/tb_nq_scaler.sv ====
// Seeded random command stream against a reference model of the gain stage
// Gain is zero after reset, so samples before the first control word give zero
`timescale 1ns/1ps

module tb_nq_scaler;

  localparam int NUM_SAMPLES = 300;
  // One full serial multiply per sample, plus reset and drain slack
  localparam int CYCLE_LIMIT = NUM_SAMPLES * 35 + 500;

  // DUT ports
  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  scaler_io_pkg::cmd_t    in_cmd;
  logic                   in_ready;
  logic                   out_valid;
  scaler_io_pkg::result_t out_result;
  logic [15:0]            sat_count;

  // Reference model state
  scaler_io_pkg::result_t exp_q [$];
  nq_fmt_pkg::nq_word_t   model_gain;
  logic [15:0]            model_sat;
  logic                   clr_pend;

  // in_ready as it stands for the coming edge
  logic drv_ready;
  logic full_seen;

  int value_errs;
  int stat_errs;
  int other_errs;
  int samples_sent;
  int results_seen;
  int cycle_cnt = 0;

  nq_scaler_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_cmd     (in_cmd),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_result (out_result),
    .sat_count  (sat_count)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Truncated Q15 product of the magnitudes, signed full scale on overflow
  function automatic scaler_io_pkg::result_t expected_result(
    input nq_fmt_pkg::nq_word_t smp,
    input nq_fmt_pkg::nq_word_t gain
  );
    scaler_io_pkg::result_t res;
    logic [63:0]            full;
    res  = '0;
    full = 64'(smp.mag) * 64'(gain.mag);
    // Whole zero word on either side gives positive zero
    if (smp == '0 || gain == '0) begin
      return res;
    end
    res.value.sign = smp.sign ^ gain.sign;
    if (|full[63:nq_fmt_pkg::MAG_BITS + nq_fmt_pkg::Q_BITS]) begin
      res.value.mag = '1;
      res.saturated = 1'b1;
    end else begin
      res.value.mag = full[nq_fmt_pkg::Q_BITS +: nq_fmt_pkg::MAG_BITS];
    end
    return res;
  endfunction

  // About 20% control words, 10% zero samples
  function automatic scaler_io_pkg::cmd_t random_cmd();
    scaler_io_pkg::cmd_t cmd;
    int unsigned         pick;
    int unsigned         range;
    cmd   = '0;
    pick  = $urandom_range(99);
    range = $urandom_range(99);
    if (pick < 20) begin
      cmd.is_ctrl                = 1'b1;
      cmd.payload.ctrl.clr_stat  = ($urandom_range(99) < 15);
      cmd.payload.ctrl.gain_sign = 1'($urandom_range(1));
      if (range < 10) begin
        cmd.payload.ctrl.gain_sign = 1'b0;
      end else if (range < 50) begin
        // Up to unity gain
        cmd.payload.ctrl.gain_mag = scaler_io_pkg::GAIN_MAG_BITS'($urandom_range(32768));
      end else if (range < 80) begin
        cmd.payload.ctrl.gain_mag = scaler_io_pkg::GAIN_MAG_BITS'($urandom_range(131071));
      end else begin
        // Large gains, most products overflow
        cmd.payload.ctrl.gain_mag = scaler_io_pkg::GAIN_MAG_BITS'($urandom());
      end
    end else if (range >= 10) begin
      cmd.payload.sample.sign = 1'($urandom_range(1));
      if (range < 55) begin
        cmd.payload.sample.mag = nq_fmt_pkg::MAG_BITS'($urandom_range(1048575));
      end else begin
        cmd.payload.sample.mag = nq_fmt_pkg::MAG_BITS'($urandom());
      end
    end
    return cmd;
  endfunction

  // Model update for one accepted word
  task automatic absorb_word(input scaler_io_pkg::cmd_t cmd);
    if (cmd.is_ctrl) begin
      model_gain.sign = cmd.payload.ctrl.gain_sign;
      model_gain.mag  = {1'b0, cmd.payload.ctrl.gain_mag};
    end else begin
      exp_q.push_back(expected_result(cmd.payload.sample, model_gain));
      samples_sent++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checks and per-cycle driver
  ////////////////////////////////////////////////////////////

  task automatic check_outputs();
    scaler_io_pkg::result_t exp_res;
    logic                   sat_event;
    sat_event = 1'b0;
    if (out_valid === 1'b1) begin
      results_seen++;
      if (exp_q.size() == 0) begin
        $display("Result at %0d ns with no sample outstanding", $time);
        other_errs++;
      end else begin
        exp_res   = exp_q.pop_front();
        sat_event = exp_res.saturated;
        if (out_result.value !== exp_res.value) begin
          $display("FAIL %0d ns out_result.value expected %h got %h",
                   $time, exp_res.value, out_result.value);
          value_errs++;
        end
        if (out_result.saturated !== exp_res.saturated) begin
          $display("FAIL %0d ns out_result.saturated expected %b got %b",
                   $time, exp_res.saturated, out_result.saturated);
          value_errs++;
        end
      end
    end
    // Clear from the previous edge beats a saturation on this one
    if (clr_pend) begin
      model_sat = '0;
    end else if (sat_event && model_sat != 16'hffff) begin
      model_sat = model_sat + 16'd1;
    end
    if (sat_count !== model_sat) begin
      $display("FAIL %0d ns sat_count expected %0d got %0d", $time, model_sat, sat_count);
      stat_errs++;
    end
  endtask

  // Sample just after the edge, then drive the next word
  task automatic step_cycle();
    logic accepted;
    @(posedge clk);
    #1;
    accepted = in_valid && drv_ready;
    check_outputs();
    clr_pend = accepted && in_cmd.is_ctrl && in_cmd.payload.ctrl.clr_stat;
    if (accepted) begin
      absorb_word(in_cmd);
    end
    if (!in_ready) begin
      full_seen = 1'b1;
      // A full queue means at least FIFO_DEPTH samples still without a result
      if (exp_q.size() < scaler_io_pkg::FIFO_DEPTH) begin
        $display("in_ready low at %0d ns with only %0d samples outstanding",
                 $time, exp_q.size());
        other_errs++;
      end
    end
    drv_ready = in_ready;
    // A refused word is held until taken
    if (!in_valid || accepted) begin
      if (samples_sent < NUM_SAMPLES) begin
        in_valid = ($urandom_range(99) < 70);
        in_cmd   = random_cmd();
      end else begin
        in_valid = 1'b0;
        in_cmd   = '0;
      end
    end
  endtask

  task automatic report_counts();
    $display("Errors: value=%0d sat_count=%0d other=%0d (samples %0d, results %0d)",
             value_errs, stat_errs, other_errs, samples_sent, results_seen);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_cmd       = '0;
    model_gain   = '0;
    model_sat    = '0;
    clr_pend     = 1'b0;
    drv_ready    = 1'b0;
    full_seen    = 1'b0;
    value_errs   = 0;
    stat_errs    = 0;
    other_errs   = 0;
    samples_sent = 0;
    results_seen = 0;
    void'($urandom(25));
    repeat (5) @(posedge clk);
    #1;
    if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
      $display("Handshake outputs not low during reset");
      other_errs++;
    end
    rst_n = 1'b1;
    while (samples_sent < NUM_SAMPLES || in_valid) begin
      step_cycle();
    end
    while (exp_q.size() != 0) begin
      step_cycle();
    end
    // Quiet tail, catches stray results
    repeat (40) step_cycle();
    if (results_seen != samples_sent) begin
      $display("Result count does not match the accepted samples");
      other_errs++;
    end
    if (!full_seen) begin
      $display("Input queue never filled, back-pressure not exercised");
      other_errs++;
    end
    report_counts();
    if (value_errs + stat_errs + other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d results outstanding", cycle_cnt, exp_q.size());
      report_counts();
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== tb/nq_scaler_props.sv ====
// Handshake assertions, bound into the multiplier and into the output stage
// HAS_OUTPUT turns on the checks that need out_valid and sat_count
`timescale 1ns/1ps

module nq_scaler_props #(
  parameter bit HAS_OUTPUT = 1'b0
) (
  input logic        clk,
  input logic        rst_n,
  input logic        hs_valid,
  input logic        hs_ready,
  input logic        res_valid,
  input logic        out_valid,
  input logic        clear_stat,
  input logic [15:0] sat_count
);

  // Operand pair in flight, from acceptance up to its result
  logic in_flight;

  // A new pair taken on the result cycle keeps the flag up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 1'b0;
    end else if (hs_valid && hs_ready) begin
      in_flight <= 1'b1;
    end else if (res_valid) begin
      in_flight <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////

  a_res_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    $past(res_valid) |-> !res_valid)
    else $error("Result valid held for more than one cycle");

  a_busy_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (in_flight && !res_valid) |-> !hs_ready)
    else $error("Ready high while an operand pair is in flight");

  // Output register is exactly one stage behind the product
  a_out_follow: assert property (@(posedge clk) disable iff (!rst_n)
    (HAS_OUTPUT && $past(res_valid)) |-> out_valid)
    else $error("Output valid missing one cycle after the product");

  a_out_source: assert property (@(posedge clk) disable iff (!rst_n)
    (HAS_OUTPUT && out_valid) |-> $past(res_valid))
    else $error("Output valid without a product one cycle earlier");

  a_sat_mono: assert property (@(posedge clk) disable iff (!rst_n)
    (HAS_OUTPUT && !$past(clear_stat)) |-> (sat_count >= $past(sat_count)))
    else $error("Saturation count dropped without a clear");

endmodule

bind nq_multiplier nq_scaler_props #(.HAS_OUTPUT(1'b0)) u_mul_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .hs_valid   (ing_valid),
  .hs_ready   (ing_ready),
  .res_valid  (egr_valid),
  .out_valid  (1'b0),
  .clear_stat (1'b0),
  .sat_count  (16'h0000)
);

bind scaler_egress nq_scaler_props #(.HAS_OUTPUT(1'b1)) u_egr_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .hs_valid   (1'b0),
  .hs_ready   (1'b0),
  .res_valid  (prod_valid),
  .out_valid  (out_valid),
  .clear_stat (clear_stat),
  .sat_count  (sat_count)
);

// ==== verilog/nq_scaler_top.sv ====
// Streaming gain stage: command queue, serial multiplier, saturating output
// Back-pressure only at the input; results leave in sample order
`timescale 1ns/1ps

module nq_scaler_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  scaler_io_pkg::cmd_t    in_cmd,
  output logic                   in_ready,
  output logic                   out_valid,
  output scaler_io_pkg::result_t out_result,
  output logic [15:0]            sat_count
);

  // Queue head toward the multiplier
  logic                   op_valid;
  logic                   op_ready;
  scaler_io_pkg::mul_op_t op;

  // Statistics clear from a control word
  logic clear_stat;

  // Multiplier result
  logic                 egr_valid;
  nq_fmt_pkg::nq_word_t egr_product;
  logic                 egr_overflow;

  ////////////////////////////////////////////////////////////
  // Datapath chain
  ////////////////////////////////////////////////////////////

  scaler_ingress u_ingress (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_cmd     (in_cmd),
    .in_ready   (in_ready),
    .op_valid   (op_valid),
    .op         (op),
    .op_ready   (op_ready),
    .clear_stat (clear_stat)
  );

  // Sample is the multiplicand, gain the multiplier
  nq_multiplier u_multiplier (
    .clk              (clk),
    .rst_n            (rst_n),
    .ing_valid        (op_valid),
    .ing_ready        (op_ready),
    .ing_multiplicand (op.sample),
    .ing_multiplier   (op.gain),
    .egr_valid        (egr_valid),
    .egr_product      (egr_product),
    .egr_overflow     (egr_overflow)
  );

  scaler_egress u_egress (
    .clk           (clk),
    .rst_n         (rst_n),
    .prod_valid    (egr_valid),
    .prod          (egr_product),
    .prod_overflow (egr_overflow),
    .clear_stat    (clear_stat),
    .out_valid     (out_valid),
    .out_result    (out_result),
    .sat_count     (sat_count)
  );

endmodule

// ==== verilog/scaler_egress.sv ====
// Output register with saturation of overflowed products
// No back-pressure, out_valid is a one-cycle pulse; sat_count holds at max
`timescale 1ns/1ps

module scaler_egress (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   prod_valid,
  input  nq_fmt_pkg::nq_word_t   prod,
  input  logic                   prod_overflow,
  input  logic                   clear_stat,
  output logic                   out_valid,
  output scaler_io_pkg::result_t out_result,
  output logic [15:0]            sat_count
);

  // A saturation event this cycle
  logic sat_hit;

  assign sat_hit = prod_valid && prod_overflow;

  ////////////////////////////////////////////////////////////
  // Control and statistics
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      sat_count <= '0;
    end else begin
      out_valid <= prod_valid;
      // Clear wins over a same-edge saturation
      if (clear_stat) begin
        sat_count <= '0;
      end else if (sat_hit && (sat_count != '1)) begin
        sat_count <= sat_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      out_result.saturated <= prod_overflow;
      // Sign kept, magnitude pinned to full scale on overflow
      out_result.value.sign <= prod.sign;
      out_result.value.mag  <= prod_overflow ? nq_fmt_pkg::MAG_MAX : prod.mag;
    end
  end

endmodule

// ==== verilog/nq_multiplier.sv ====
// Serial shift-and-add sign-magnitude multiplier, one operand pair at a time
// Product is truncated; a whole zero operand word returns positive zero early
`timescale 1ns/1ps

module nq_multiplier (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ing_valid,
  output logic                 ing_ready,
  input  nq_fmt_pkg::nq_word_t ing_multiplicand,
  input  nq_fmt_pkg::nq_word_t ing_multiplier,
  output logic                 egr_valid,
  output nq_fmt_pkg::nq_word_t egr_product,
  output logic                 egr_overflow
);

  // Operand pair taken this cycle
  logic accept;
  logic zero_op;

  // Sequencing flags
  logic busy;
  logic finish;
  logic zero_pend;
  logic [nq_fmt_pkg::STEP_BITS-1:0] step;

  // Datapath registers
  logic                               sign_r;
  logic [nq_fmt_pkg::N_BITS-1:0]      mcand_r;
  logic [nq_fmt_pkg::PROD_BITS-1:0]   mplier_r;
  logic [nq_fmt_pkg::PROD_BITS-1:0]   product_r;

  assign accept  = ing_valid && ing_ready;
  assign zero_op = !(|ing_multiplicand) || !(|ing_multiplier);

  // Drop the fraction bits below the kept window
  assign egr_product.sign = sign_r;
  assign egr_product.mag  = product_r[nq_fmt_pkg::Q_BITS +: nq_fmt_pkg::MAG_BITS];

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ing_ready    <= 1'b0;
      egr_valid    <= 1'b0;
      egr_overflow <= 1'b0;
      busy         <= 1'b0;
      finish       <= 1'b0;
      zero_pend    <= 1'b0;
      step         <= '0;
    end else begin
      egr_valid <= 1'b0;
      if (accept) begin
        // Overflow belongs to the new pair from here on
        ing_ready    <= 1'b0;
        egr_overflow <= 1'b0;
        step         <= '0;
        if (zero_op) begin
          zero_pend <= 1'b1;
        end else begin
          busy <= 1'b1;
        end
      end else if (zero_pend) begin
        // Shortcut, result on the first edge after acceptance
        zero_pend <= 1'b0;
        egr_valid <= 1'b1;
        ing_ready <= 1'b1;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == nq_fmt_pkg::STEP_BITS'(nq_fmt_pkg::N_BITS - 1)) begin
          busy   <= 1'b0;
          finish <= 1'b1;
        end
      end else if (finish) begin
        // Product complete, judge the bits above the kept window
        finish       <= 1'b0;
        egr_valid    <= 1'b1;
        ing_ready    <= 1'b1;
        egr_overflow <=
          |product_r[nq_fmt_pkg::PROD_BITS-1 : nq_fmt_pkg::MAG_BITS + nq_fmt_pkg::Q_BITS];
      end else begin
        // Idle, also the first cycle out of reset
        ing_ready <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      // Strip the signs, keep only magnitudes
      mcand_r   <= {1'b0, ing_multiplicand.mag};
      mplier_r  <= nq_fmt_pkg::PROD_BITS'(ing_multiplier.mag);
      product_r <= '0;
      // Zero shortcut always yields positive zero
      sign_r    <= zero_op ? 1'b0 : (ing_multiplicand.sign ^ ing_multiplier.sign);
    end else if (busy) begin
      // One partial product per multiplicand bit
      if (mcand_r[step]) begin
        product_r <= product_r + mplier_r;
      end
      mplier_r <= mplier_r << 1;
    end
  end

endmodule

// ==== verilog/scaler_ingress.sv ====
// Command decode, gain register and sample queue; gain is zero after reset
// Control words are taken whenever in_ready is high, samples fill the queue
`timescale 1ns/1ps

module scaler_ingress (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  scaler_io_pkg::cmd_t    in_cmd,
  output logic                   in_ready,
  output logic                   op_valid,
  output scaler_io_pkg::mul_op_t op,
  input  logic                   op_ready,
  output logic                   clear_stat
);

  // Handshake events
  logic accept;
  logic push;
  logic pop;

  // Queue pointers and occupancy
  logic [scaler_io_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
  logic [scaler_io_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
  logic [scaler_io_pkg::FIFO_CNT_BITS-1:0] count;
  logic [scaler_io_pkg::FIFO_CNT_BITS-1:0] count_next;

  // Gain in force for newly accepted samples
  nq_fmt_pkg::nq_word_t gain_r;

  // Queue storage
  scaler_io_pkg::mul_op_t fifo_mem [scaler_io_pkg::FIFO_DEPTH];

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  assign accept = in_valid && in_ready;

  // Only sample words enter the queue
  assign push = accept && !in_cmd.is_ctrl;

  // Head leaves when the multiplier takes it
  assign pop = op_valid && op_ready;

  // Head is valid whenever something is queued
  assign op_valid = (count != '0);
  assign op       = fifo_mem[rd_ptr];

  // Next occupancy
  always_comb begin
    count_next = count;
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      in_ready   <= 1'b0;
      gain_r     <= '0;
      clear_stat <= 1'b0;
    end else begin
      count <= count_next;

      // Registered full flag, low in reset and up on the first edge after it
      in_ready <= (count_next != scaler_io_pkg::FIFO_CNT_BITS'(scaler_io_pkg::FIFO_DEPTH));

      // Pointers wrap on their own, depth is a power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // One-cycle clear request toward the counter
      clear_stat <= accept && in_cmd.is_ctrl && in_cmd.payload.ctrl.clr_stat;

      // New gain applies from the next accepted sample
      if (accept && in_cmd.is_ctrl) begin
        gain_r.sign <= in_cmd.payload.ctrl.gain_sign;
        gain_r.mag  <= {1'b0, in_cmd.payload.ctrl.gain_mag};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Queue storage
  ////////////////////////////////////////////////////////////

  // Sample is paired with the gain as it stands at its own edge
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr].sample <= in_cmd.payload.sample;
      fifo_mem[wr_ptr].gain   <= gain_r;
    end
  end

endmodule

// ==== verilog/scaler_io_pkg.sv ====
// Stream level types for the gain stage: command word, queue entry and result
// The command payload is one word read either as a sample or as a control word
package scaler_io_pkg;

  ////////////////////////////////////////////////////////////
  // Queue sizing
  ////////////////////////////////////////////////////////////

  // Sample queue depth, kept a power of two so pointers wrap freely
  localparam int FIFO_DEPTH = 4;

  // Pointer width into the queue
  localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

  // Occupancy width, must also hold the full value
  localparam int FIFO_CNT_BITS = $clog2(FIFO_DEPTH + 1);

  // Gain magnitude width carried in a control word
  localparam int GAIN_MAG_BITS = nq_fmt_pkg::MAG_BITS - 1;

  ////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////

  // Control view of the payload word
  typedef struct packed {
    logic                     clr_stat;
    logic                     gain_sign;
    logic [GAIN_MAG_BITS-1:0] gain_mag;
  } ctrl_view_t;

  // Same word, two readings picked by is_ctrl
  typedef union packed {
    nq_fmt_pkg::nq_word_t sample;
    ctrl_view_t           ctrl;
  } cmd_payload_u;

  // Tag bit on top of the payload, 33 bits
  typedef struct packed {
    logic         is_ctrl;
    cmd_payload_u payload;
  } cmd_t;

  // Queue entry, sample with the gain in force when it arrived
  typedef struct packed {
    nq_fmt_pkg::nq_word_t sample;
    nq_fmt_pkg::nq_word_t gain;
  } mul_op_t;

  // Output word plus the saturation marker
  typedef struct packed {
    nq_fmt_pkg::nq_word_t value;
    logic                 saturated;
  } result_t;

endpackage

// ==== verilog/nq_fmt_pkg.sv ====
// Sign-magnitude fixed-point format shared by the multiplier and the stream side
// Sign bit on top, magnitude below, Q_BITS of the magnitude are fraction bits
package nq_fmt_pkg;

  ////////////////////////////////////////////////////////////
  // Word geometry
  ////////////////////////////////////////////////////////////

  // Full word width including the sign bit
  localparam int N_BITS = 32;

  // Fraction bits inside the magnitude
  localparam int Q_BITS = 15;

  // Magnitude width, everything below the sign
  localparam int MAG_BITS = N_BITS - 1;

  // Largest magnitude, used as the saturation value
  localparam logic [MAG_BITS-1:0] MAG_MAX = '1;

  ////////////////////////////////////////////////////////////
  // Multiplier internals
  ////////////////////////////////////////////////////////////

  // Full magnitude product width, two magnitudes plus one spare bit
  localparam int PROD_BITS = 2 * N_BITS - 1;

  // Counter width for one partial product per word bit
  localparam int STEP_BITS = $clog2(N_BITS);

  // One number, sign and magnitude
  typedef struct packed {
    logic                sign;
    logic [MAG_BITS-1:0] mag;
  } nq_word_t;

endpackage
